// File: design/fpu_pkg.sv
package fpu_pkg;

  // ==========================================================================
  // Data widths
  // ==========================================================================

  // Two packed singles, low lane in [31:0].
  typedef logic [63:0] fp_data_t;

  // One single-precision lane.
  typedef logic [31:0] fp_lane_t;

  // Exception flags, laid out as in the control register.
  // Bits: invalid, denormal, divide-by-zero, overflow, underflow.
  typedef logic [4:0] fp_flags_t;

  localparam int flag_inv = 0;
  localparam int flag_dn  = 1;

  // Unit-of-work tag of the issuing instruction.
  typedef logic [5:0] fp_tag_t;

  // Zero is no forward, n picks bus n-1.
  typedef logic [2:0] fwd_sel_t;

  // Index of the lowest unmasked flag.
  typedef logic [2:0] exc_idx_t;

  // Tag in the upper bits, flag index below.
  typedef logic [8:0] ret_code_t;

  // ==========================================================================
  // Opcodes
  // ==========================================================================

  typedef enum logic [3:0] {
    fop_and   = 4'd0,
    fop_or    = 4'd1,
    fop_xor   = 4'd2,
    fop_andn  = 4'd3,   // a & ~b.
    fop_swap  = 4'd4,
    fop_dupl  = 4'd5,
    fop_duph  = 4'd6,
    fop_neg   = 4'd7,
    fop_abs   = 4'd8,
    fop_cmplt = 4'd9,
    fop_cmple = 4'd10,
    fop_cmpeq = 4'd11
  } fp_op_t;              // 12..15 illegal.

  // ==========================================================================
  // Single-precision field layout
  // ==========================================================================

  localparam int sgl_sign_bit = 31;
  localparam int sgl_qnan_bit = 22;

endpackage

// File: design/fpu_result_if.sv
`timescale 1ns/1ps

// One result per valid strobe; fields only meaningful while valid is high.
interface fpu_result_if
  import fpu_pkg::*;
();

  logic      valid;
  fp_tag_t   tag;
  fp_data_t  res;
  fp_flags_t flags;

  modport prod (
    output valid,
    output tag,
    output res,
    output flags
  );

  modport cons (
    input valid,
    input tag,
    input res,
    input flags
  );

endinterface

// File: design/fpu_operand_fwd.sv
`timescale 1ns/1ps

module fpu_operand_fwd
  import fpu_pkg::*;
#(
  parameter int NUM_FWD = 4
) (
  input  logic     clk,
  input  logic     rst,
  input  fwd_sel_t fwd_sel,
  input  fwd_sel_t fwdd_sel,
  input  fp_data_t port_data,
  input  fp_data_t fwd_bus [NUM_FWD],
  output fp_data_t operand
);

  // Copy of every bus as seen at the last edge.
  fp_data_t fwd_q [NUM_FWD];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_FWD; i++) begin
        fwd_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_FWD; i++) begin
        fwd_q[i] <= fwd_bus[i];
      end
    end
  end

  // ==========================================================================
  // Operand select
  // ==========================================================================

  // Later assignments win, so the current bus overrides the delayed one.
  always_comb begin
    operand = port_data;
    for (int i = 0; i < NUM_FWD; i++) begin
      if (fwdd_sel == fwd_sel_t'(i + 1)) begin
        operand = fwd_q[i];
      end
    end
    for (int i = 0; i < NUM_FWD; i++) begin
      if (fwd_sel == fwd_sel_t'(i + 1)) begin
        operand = fwd_bus[i];
      end
    end
  end

endmodule

// File: design/fpu_exec.sv
`timescale 1ns/1ps

module fpu_exec
  import fpu_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     en,
  input  fp_op_t   op,
  input  logic     ord,
  input  fp_tag_t  tag,
  input  fp_data_t a,
  input  fp_data_t b,
  fpu_result_if.prod res_out
);

  fp_lane_t  a_lo;
  fp_lane_t  b_lo;
  logic      a_nan, b_nan, a_snan, b_snan;
  logic      a_dn, b_dn;
  logic      any_nan, both_zero;
  logic      cmp_eq, cmp_lt;
  logic      cmp_res;
  fp_data_t  res_d;
  fp_flags_t flags_d;

  assign a_lo = a[31:0];
  assign b_lo = b[31:0];

  // ==========================================================================
  // Low-lane classification
  // ==========================================================================

  assign a_nan  = (a_lo[30:23] == 8'hff) && (a_lo[22:0] != '0);
  assign b_nan  = (b_lo[30:23] == 8'hff) && (b_lo[22:0] != '0);
  assign a_snan = a_nan && !a_lo[sgl_qnan_bit];
  assign b_snan = b_nan && !b_lo[sgl_qnan_bit];
  assign a_dn   = (a_lo[30:23] == 8'h00) && (a_lo[22:0] != '0);
  assign b_dn   = (b_lo[30:23] == 8'h00) && (b_lo[22:0] != '0);

  assign any_nan   = a_nan || b_nan;
  assign both_zero = (a_lo[30:0] == '0) && (b_lo[30:0] == '0);

  // Sign-magnitude ordering; denormals compare exactly as encoded.
  always_comb begin
    cmp_eq = !any_nan && ((a_lo == b_lo) || both_zero);
    cmp_lt = 1'b0;
    if (!any_nan && !both_zero) begin
      if (a_lo[sgl_sign_bit] != b_lo[sgl_sign_bit]) begin
        cmp_lt = a_lo[sgl_sign_bit];
      end else if (a_lo[sgl_sign_bit]) begin
        cmp_lt = a_lo[30:0] > b_lo[30:0];
      end else begin
        cmp_lt = a_lo[30:0] < b_lo[30:0];
      end
    end
  end

  // ==========================================================================
  // Result select
  // ==========================================================================

  always_comb begin
    res_d   = '0;
    flags_d = '0;
    cmp_res = 1'b0;
    case (op)
      fop_and:   res_d = a & b;
      fop_or:    res_d = a | b;
      fop_xor:   res_d = a ^ b;
      fop_andn:  res_d = a & ~b;
      fop_swap:  res_d = {a[31:0], b[63:32]};
      fop_dupl:  res_d = {a[31:0], a[31:0]};
      fop_duph:  res_d = {a[63:32], a[63:32]};
      fop_neg:   res_d = a ^ 64'h8000_0000_8000_0000;
      fop_abs:   res_d = a & 64'h7fff_ffff_7fff_ffff;
      fop_cmplt, fop_cmple, fop_cmpeq: begin
        if (op == fop_cmplt) begin
          cmp_res = cmp_lt;
        end else if (op == fop_cmple) begin
          cmp_res = cmp_lt || cmp_eq;
        end else begin
          cmp_res = cmp_eq;
        end
        res_d              = {32'h0, {32{cmp_res}}};
        flags_d[flag_inv]  = a_snan || b_snan || (any_nan && ord);
        flags_d[flag_dn]   = a_dn || b_dn;
      end
      default: res_d = '0;  // Illegal opcode.
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res_out.valid <= 1'b0;
    end else begin
      res_out.valid <= en;
    end
    res_out.tag   <= tag;
    res_out.res   <= res_d;
    res_out.flags <= flags_d;
  end

endmodule

// File: design/fpu_result_pipe.sv
`timescale 1ns/1ps

module fpu_result_pipe
  import fpu_pkg::*;
#(
  parameter int PIPE_DEPTH = 2
) (
  input logic clk,
  input logic rst,
  fpu_result_if.cons in_if,
  fpu_result_if.prod out_if
);

  // Stage 0 is nearest the execute side.
  logic      vld_q   [PIPE_DEPTH];
  fp_tag_t   tag_q   [PIPE_DEPTH];
  fp_data_t  res_q   [PIPE_DEPTH];
  fp_flags_t flags_q [PIPE_DEPTH];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < PIPE_DEPTH; i++) begin
        vld_q[i] <= 1'b0;
      end
    end else begin
      vld_q[0] <= in_if.valid;
      for (int i = 1; i < PIPE_DEPTH; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
    end
    tag_q[0]   <= in_if.tag;
    res_q[0]   <= in_if.res;
    flags_q[0] <= in_if.flags;
    for (int i = 1; i < PIPE_DEPTH; i++) begin
      tag_q[i]   <= tag_q[i-1];
      res_q[i]   <= res_q[i-1];
      flags_q[i] <= flags_q[i-1];
    end
  end

  assign out_if.valid = vld_q[PIPE_DEPTH-1];
  assign out_if.tag   = tag_q[PIPE_DEPTH-1];
  assign out_if.res   = res_q[PIPE_DEPTH-1];
  assign out_if.flags = flags_q[PIPE_DEPTH-1];

endmodule

// File: design/fpu_excpt_retire.sv
`timescale 1ns/1ps

module fpu_excpt_retire
  import fpu_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  fpu_result_if.cons in_if,
  input  fp_flags_t exc_en,
  output logic      res_valid,
  output fp_tag_t   res_tag,
  output fp_data_t  res_data,
  output logic      ret_en,
  output ret_code_t ret_code,
  output fp_flags_t sticky_flags
);

  fp_flags_t masked;
  exc_idx_t  low_idx;

  assign masked = in_if.flags & exc_en;

  // Lowest set bit wins, invalid first.
  always_comb begin
    low_idx = '0;
    for (int i = $bits(fp_flags_t) - 1; i >= 0; i--) begin
      if (masked[i]) begin
        low_idx = exc_idx_t'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid    <= 1'b0;
      ret_en       <= 1'b0;
      ret_code     <= '0;
      sticky_flags <= '0;
    end else begin
      res_valid <= in_if.valid;
      ret_en    <= in_if.valid && (masked != '0);
      ret_code  <= '0;
      if (in_if.valid) begin
        sticky_flags <= sticky_flags | in_if.flags;
        if (masked != '0) begin
          ret_code <= {in_if.tag, low_idx};
        end
      end
    end
    if (in_if.valid) begin  // Payload held between results.
      res_tag  <= in_if.tag;
      res_data <= in_if.res;
    end
  end

endmodule

// File: design/fpu_unit_top.sv
`timescale 1ns/1ps

module fpu_unit_top
  import fpu_pkg::*;
#(
  parameter int NUM_FWD    = 4,
  parameter int PIPE_DEPTH = 2
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      issue_en,
  input  fp_op_t    issue_op,
  input  logic      issue_ord,
  input  fp_tag_t   issue_tag,
  input  fp_data_t  issue_a,
  input  fp_data_t  issue_b,
  input  fwd_sel_t  fwd_sel_a,
  input  fwd_sel_t  fwd_sel_b,
  input  fwd_sel_t  fwdd_sel_a,
  input  fwd_sel_t  fwdd_sel_b,
  input  fp_data_t  fwd_bus [NUM_FWD],
  input  fp_flags_t exc_en,
  output logic      res_valid,
  output fp_tag_t   res_tag,
  output fp_data_t  res_data,
  output logic      ret_en,
  output ret_code_t ret_code,
  output fp_flags_t sticky_flags
);

  fp_data_t opnd_a;
  fp_data_t opnd_b;

  fpu_result_if exec_if ();
  fpu_result_if pipe_if ();

  fpu_operand_fwd #(.NUM_FWD(NUM_FWD)) fwd_a_i (
    .clk(clk), .rst(rst), .fwd_sel(fwd_sel_a), .fwdd_sel(fwdd_sel_a),
    .port_data(issue_a), .fwd_bus(fwd_bus), .operand(opnd_a)
  );

  fpu_operand_fwd #(.NUM_FWD(NUM_FWD)) fwd_b_i (
    .clk(clk), .rst(rst), .fwd_sel(fwd_sel_b), .fwdd_sel(fwdd_sel_b),
    .port_data(issue_b), .fwd_bus(fwd_bus), .operand(opnd_b)
  );

  fpu_exec exec_i (
    .clk(clk), .rst(rst), .en(issue_en), .op(issue_op), .ord(issue_ord),
    .tag(issue_tag), .a(opnd_a), .b(opnd_b), .res_out(exec_if.prod)
  );

  fpu_result_pipe #(.PIPE_DEPTH(PIPE_DEPTH)) pipe_i (
    .clk(clk), .rst(rst), .in_if(exec_if.cons), .out_if(pipe_if.prod)
  );

  fpu_excpt_retire retire_i (
    .clk(clk), .rst(rst), .in_if(pipe_if.cons), .exc_en(exc_en),
    .res_valid(res_valid), .res_tag(res_tag), .res_data(res_data),
    .ret_en(ret_en), .ret_code(ret_code), .sticky_flags(sticky_flags)
  );

endmodule

// File: verif/fpu_unit_tb.sv
`timescale 1ns/1ps

module fpu_unit_tb
  import fpu_pkg::*;
();

  localparam int NUM_FWD   = 4;
  localparam int LATENCY   = 4;    // Drive cycle to result cycle.
  localparam int NUM_PHASE = 8;
  localparam int PHASE_OPS = 400;
  localparam int DRAIN_MAX = 50;

  typedef struct {
    int        due;
    fp_tag_t   tag;
    fp_data_t  data;
    fp_flags_t flags;
    logic      ret;
    ret_code_t code;
  } exp_item_t;

  logic      clk = 1'b0;
  logic      rst;
  logic      issue_en;
  fp_op_t    issue_op;
  logic      issue_ord;
  fp_tag_t   issue_tag;
  fp_data_t  issue_a;
  fp_data_t  issue_b;
  fwd_sel_t  fwd_sel_a;
  fwd_sel_t  fwd_sel_b;
  fwd_sel_t  fwdd_sel_a;
  fwd_sel_t  fwdd_sel_b;
  fp_data_t  fwd_bus [NUM_FWD];
  fp_flags_t exc_en;
  logic      res_valid;
  fp_tag_t   res_tag;
  fp_data_t  res_data;
  logic      ret_en;
  ret_code_t ret_code;
  fp_flags_t sticky_flags;

  fp_data_t  prev_bus [NUM_FWD];   // Bus values seen at the last edge.
  exp_item_t exp_q [$];
  fp_flags_t sticky_model = '0;
  int        cyc = 0;

  fpu_unit_top fpu_unit_top_i (.*);

  always #5 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  // ==========================================================================
  // Checking
  // ==========================================================================

  task automatic stop_on_error();
    $display("sim failed");
    $fatal(1, "Run stopped at the first error.");
  endtask

  task automatic check_value(input string what, input logic [63:0] act,
                             input logic [63:0] exp);
    if (act !== exp) begin
      $display("FAILED at %0t: %s is %h, expected %h", $time, what, act, exp);
      stop_on_error();
    end
  endtask

  // ==========================================================================
  // Reference model
  // ==========================================================================

  function automatic logic is_nan(input fp_lane_t x);
    return (x[30:23] == 8'hff) && (x[22:0] != 0);
  endfunction

  function automatic logic is_snan(input fp_lane_t x);
    return is_nan(x) && !x[22];
  endfunction

  function automatic logic is_dn(input fp_lane_t x);
    return (x[30:23] == 8'h00) && (x[22:0] != 0);
  endfunction

  // Signed ordering key where both zeros map to 0.
  function automatic int order_key(input fp_lane_t x);
    return x[31] ? -int'(x[30:0]) : int'(x[30:0]);
  endfunction

  function automatic fp_data_t pick_operand(input fwd_sel_t sel, input fwd_sel_t dsel,
                                            input fp_data_t port);
    if (sel != 0) return fwd_bus[sel - 1];
    if (dsel != 0) return prev_bus[dsel - 1];
    return port;
  endfunction

  task automatic model_op(input fp_op_t op, input logic ord, input fp_data_t a,
                          input fp_data_t b, output fp_data_t res, output fp_flags_t flags);
    fp_lane_t al;
    fp_lane_t bl;
    logic     nan;
    logic     hit;
    al    = a[31:0];
    bl    = b[31:0];
    res   = '0;
    flags = '0;
    nan   = is_nan(al) || is_nan(bl);
    case (op)
      fop_and:  res = a & b;
      fop_or:   res = a | b;
      fop_xor:  res = a ^ b;
      fop_andn: res = a & ~b;
      fop_swap: res = {a[31:0], b[63:32]};
      fop_dupl: res = {2{a[31:0]}};
      fop_duph: res = {2{a[63:32]}};
      fop_neg:  res = {~a[63], a[62:32], ~a[31], a[30:0]};
      fop_abs:  res = {1'b0, a[62:32], 1'b0, a[30:0]};
      fop_cmplt, fop_cmple, fop_cmpeq: begin
        if (op == fop_cmplt) begin
          hit = order_key(al) < order_key(bl);
        end else if (op == fop_cmple) begin
          hit = order_key(al) <= order_key(bl);
        end else begin
          hit = order_key(al) == order_key(bl);
        end
        res[31:0]       = {32{hit && !nan}};
        flags[flag_inv] = is_snan(al) || is_snan(bl) || (nan && ord);
        flags[flag_dn]  = is_dn(al) || is_dn(bl);
      end
      default: res = '0;   // Illegal opcode.
    endcase
  endtask

  // ==========================================================================
  // Stimulus
  // ==========================================================================

  // Lane pool leaning on the special encodings.
  function automatic fp_lane_t rand_lane();
    logic sgn;
    sgn = $urandom % 2;
    case ($urandom % 8)
      0: return {sgn, 8'hff, 1'b1, 22'($urandom)};           // Quiet NaN.
      1: return {sgn, 8'hff, 1'b0, 22'($urandom) | 22'h1};   // Signaling NaN.
      2: return {sgn, 8'h00, 23'($urandom) | 23'h1};
      3: return {sgn, 31'h0};
      4: return {sgn, 8'h7f, 23'($urandom % 4)};             // Near-equal normals.
      default: return fp_lane_t'($urandom);
    endcase
  endfunction

  function automatic fp_data_t rand_data();
    return {rand_lane(), rand_lane()};
  endfunction

  function automatic fwd_sel_t pick_sel();
    if ($urandom % 2) return '0;
    return fwd_sel_t'(1 + $urandom % NUM_FWD);
  endfunction

  task automatic issue_cycle(input logic allow_issue);
    fp_data_t  exp_res;
    fp_flags_t exp_flags;
    fp_flags_t masked;
    exp_item_t item;
    int        flag_idx;
    @(posedge clk);
    #1;
    issue_a = rand_data();
    issue_b = ($urandom % 5 == 0) ? issue_a : rand_data();   // Equal pairs.
    for (int i = 0; i < NUM_FWD; i++) begin
      prev_bus[i] = fwd_bus[i];
      fwd_bus[i]  = ($urandom % 5 == 0) ? issue_a : rand_data();
    end
    issue_en   = allow_issue && ($urandom % 10 < 7);
    issue_op   = fp_op_t'($urandom % 16);
    issue_ord  = $urandom % 2;
    issue_tag  = fp_tag_t'($urandom);
    fwd_sel_a  = pick_sel();
    fwd_sel_b  = pick_sel();
    fwdd_sel_a = pick_sel();
    fwdd_sel_b = pick_sel();
    if (issue_en) begin
      model_op(issue_op, issue_ord, pick_operand(fwd_sel_a, fwdd_sel_a, issue_a),
               pick_operand(fwd_sel_b, fwdd_sel_b, issue_b), exp_res, exp_flags);
      masked     = exp_flags & exc_en;
      item.due   = cyc + LATENCY;
      item.tag   = issue_tag;
      item.data  = exp_res;
      item.flags = exp_flags;
      item.ret   = (masked != 0);
      item.code  = '0;
      if (masked != 0) begin
        flag_idx = 0;   // Scan up from invalid.
        while (!masked[flag_idx]) begin
          flag_idx++;
        end
        item.code = {issue_tag, 3'(flag_idx)};
      end
      exp_q.push_back(item);
    end
  endtask

  task automatic wait_for_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
      waited++;
      if (waited > DRAIN_MAX) begin
        $display("Timeout: %0d results never came back from the DUT.", exp_q.size());
        stop_on_error();
      end
    end
  endtask

  function automatic fp_flags_t pick_exc_en(input int phase);
    case (phase)
      0: return 5'h00;
      1: return 5'h01;
      2: return 5'h02;
      3: return 5'h03;
      4: return 5'h1f;
      default: return fp_flags_t'($urandom);
    endcase
  endfunction

  // ==========================================================================
  // Result monitor
  // ==========================================================================

  always @(negedge clk) begin : monitor
    exp_item_t item;
    if (rst === 1'b0) begin
      if (res_valid === 1'b1) begin
        if (exp_q.size() == 0) begin
          $display("Unexpected result with tag %h and no operation outstanding.", res_tag);
          stop_on_error();
        end
        item         = exp_q.pop_front();
        sticky_model = sticky_model | item.flags;
        check_value("result cycle", cyc, item.due);
        check_value("res_tag", res_tag, item.tag);
        check_value("res_data", res_data, item.data);
        check_value("ret_en", ret_en, item.ret);
        check_value("ret_code", ret_code, item.code);
      end else begin
        check_value("res_valid", res_valid, 1'b0);
        check_value("ret_en", ret_en, 1'b0);
        check_value("ret_code", ret_code, '0);
      end
      check_value("sticky_flags", sticky_flags, sticky_model);
    end
  end

  initial begin
    void'($urandom(32'h58cd_205d));
    rst        = 1'b1;
    issue_en   = 1'b0;
    issue_op   = fop_and;
    issue_ord  = 1'b0;
    issue_tag  = '0;
    issue_a    = '0;
    issue_b    = '0;
    fwd_sel_a  = '0;
    fwd_sel_b  = '0;
    fwdd_sel_a = '0;
    fwdd_sel_b = '0;
    exc_en     = '0;
    for (int i = 0; i < NUM_FWD; i++) begin
      fwd_bus[i]  = '0;
      prev_bus[i] = '0;
    end
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    repeat (5) issue_cycle(1'b0);   // Quiet outputs before the first issue.
    for (int phase = 0; phase < NUM_PHASE; phase++) begin
      issue_cycle(1'b0);
      wait_for_drain();
      #1;
      exc_en = pick_exc_en(phase);   // Only with nothing in flight.
      for (int n = 0; n < PHASE_OPS; n++) begin
        issue_cycle(1'b1);
      end
    end
    issue_cycle(1'b0);
    wait_for_drain();
    $display("sim passed");
    $finish;
  end

endmodule

// File: sim.f
design/fpu_pkg.sv
design/fpu_result_if.sv
design/fpu_operand_fwd.sv
design/fpu_exec.sv
design/fpu_result_pipe.sv
design/fpu_excpt_retire.sv
design/fpu_unit_top.sv
verif/fpu_unit_tb.sv

// File: Bender.yml
package:
  name: fpu_unit

sources:
  # Design, in compile order.
  - files:
      - design/fpu_pkg.sv
      - design/fpu_result_if.sv
      - design/fpu_operand_fwd.sv
      - design/fpu_exec.sv
      - design/fpu_result_pipe.sv
      - design/fpu_excpt_retire.sv
      - design/fpu_unit_top.sv

  # Testbench.
  - target: simulation
    files:
      - verif/fpu_unit_tb.sv
